// ==== files.f ====
+incdir+verilog
verilog/videoPkg.sv
verilog/inputPkg.sv
verilog/padReader.sv
verilog/videoTiming.sv
verilog/spriteRegs.sv
verilog/pixelMixer.sv
verilog/gameBox.sv
sim/gameBoxChecker.sv
sim/gameBoxTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# Builds the gameBox testbench with Verilator, runs it and checks the log

set -u

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module gameBoxTb -Mdir "$buildDir" -o gameBoxSim -f files.f
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "Verilator build failed with status $buildStatus"
    exit 1
fi

"./$buildDir/gameBoxSim" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$logFile"; then
    exit 1
fi
exit 0

// ==== sim/gameBoxChecker.sv ====
// Watches the gameBox outputs and compares them with a model of the display
// The scan position locks to the first vSync fall, a sprite model steps at
// every frameEnd, and sync, pixel and button mismatches are counted.
// frameEnd is held against the scan and padSelect against its phase count
`timescale 1ns/1ps
`default_nettype none
`include "gameBox_macros.svh"

module gameBoxChecker import videoPkg::*, inputPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      hSync,
    input  logic      vSync,
    input  rgbColor   rgb,
    input  padButtons buttons,
    input  logic      frameEnd,
    input  logic      padSelect,
    input  padButtons pressed,
    output logic      done,
    output int        errorTotal
);

    localparam int lineCycles   = 2 * `H_TOTAL;
    localparam int hSyncStart   = `H_VISIBLE + `H_FRONT;
    localparam int vSyncStart   = `V_VISIBLE + `V_FRONT;
    localparam int xMax         = `H_VISIBLE - `SPRITE_SIZE;
    localparam int yMax         = `V_VISIBLE - `SPRITE_SIZE;
    // A change can miss the poll in progress, so allow two whole polls
    localparam int settleCycles = 4 * `PAD_PHASE_CYCLES;
    localparam int framesToRun  = 5;

    int syncErrors   = 0;
    int pixelErrors  = 0;
    int buttonErrors = 0;

    // Tracked output position and pulse measurements
    int        tx;
    int        ty;
    int        hLow;
    int        vLow;
    int        sinceHFall;
    int        sinceChange;
    int        frames;
    logic      locked;
    logic      tickPhase;
    logic      prevH;
    logic      prevV;
    logic      expFrameEnd;
    padButtons lastPressed;

    // Select phase model
    int   selCnt;
    logic expSel;

    // Sprite model
    int         sprX;
    int         sprY;
    logic [1:0] sprIdx;
    logic       sprShown;
    logic       startSeen;

    assign errorTotal = syncErrors + pixelErrors + buttonErrors;

    // Expected colour of one output pixel
    function automatic logic [11:0] refColor(input int x, input int y, input logic bgPixel,
                                             input int sx, input int sy,
                                             input logic [1:0] idx, input logic shown);
        logic [11:0] color;
        color = 12'h000;
        if (x < `H_VISIBLE && y < `V_VISIBLE) begin
            if (shown && x >= sx && x < sx + `SPRITE_SIZE && y >= sy && y < sy + `SPRITE_SIZE) begin
                case (idx)
                    2'd0:    color = 12'hF00;
                    2'd1:    color = 12'h0F0;
                    2'd2:    color = 12'h00F;
                    default: color = 12'hFF0;
                endcase
            end else if (bgPixel) begin
                color = 12'hFFF;
            end
        end
        return color;
    endfunction

    task automatic stepSprite(input padButtons btn);
        if (btn.b) begin
            sprX = `X_START;
            sprY = `Y_START;
        end else begin
            if (btn.right != btn.left) sprX = btn.right ? sprX + 1 : sprX - 1;
            if (btn.down != btn.up) sprY = btn.down ? sprY + 1 : sprY - 1;
            sprX = (sprX < 0) ? 0 : (sprX > xMax) ? xMax : sprX;
            sprY = (sprY < 0) ? 0 : (sprY > yMax) ? yMax : sprY;
        end
        if (btn.a) sprIdx = sprIdx + 2'd1;
        if (btn.start && !startSeen) sprShown = !sprShown;
        startSeen = btn.start;
    endtask

    task automatic checkTick();
        logic [11:0] expColor;
        logic        bgPixel;
        logic        expH;
        logic        expV;
        bgPixel = 1'b0;
        if (tx < `H_VISIBLE && ty < `V_VISIBLE) begin
            bgPixel = gameBoxTb.bgCopy[(ty >> `BG_SHIFT) * `BG_WIDTH + (tx >> `BG_SHIFT)];
        end
        expColor = refColor(tx, ty, bgPixel, sprX, sprY, sprIdx, sprShown);
        expH = !(tx >= hSyncStart && tx < hSyncStart + `H_SYNC);
        expV = !(ty >= vSyncStart && ty < vSyncStart + `V_SYNC);
        if (rgb !== expColor) begin
            pixelErrors++;
            $display("ERROR at %0t: pixel (%0d,%0d) expected rgb %03h, seen %03h",
                     $time, tx, ty, expColor, rgb);
        end
        if (hSync !== expH || vSync !== expV) begin
            syncErrors++;
            $display("ERROR at %0t: syncs at (%0d,%0d) expected h%b v%b, seen h%b v%b",
                     $time, tx, ty, expH, expV, hSync, vSync);
        end
    endtask

    // Outputs only move on rising edges, so they are sampled on the falling one
    always @(negedge clk) begin
        if (rst) begin
            locked = 1'b0;
            tickPhase = 1'b0;
            prevH = 1'b1;
            prevV = 1'b1;
            hLow = 0;
            vLow = 0;
            sinceHFall = -1;
            sinceChange = 0;
            lastPressed = pressed;
            frames = 0;
            selCnt = 0;
            expSel = 1'b1;
            sprX = `X_START;
            sprY = `Y_START;
            sprIdx = 2'd0;
            sprShown = 1'b1;
            startSeen = 1'b0;
            done = 1'b0;
        end else if (!done) begin
            // First vSync fall belongs to x 0, y 490
            if (!locked && prevV && !vSync) begin
                locked = 1'b1;
                tx = 0;
                ty = vSyncStart;
                tickPhase = 1'b0;
            end
            if (locked) begin
                // Each pixel tick lasts two clk cycles
                if (!tickPhase) begin
                    checkTick();
                end else begin
                    tx++;
                    if (tx == `H_TOTAL) begin
                        tx = 0;
                        ty = (ty == `V_TOTAL - 1) ? 0 : ty + 1;
                    end
                end
                tickPhase = !tickPhase;

                // Here tx, ty is the scan position inside the uut
                expFrameEnd = tx == `H_TOTAL - 1 && ty == `V_VISIBLE - 1 && !tickPhase;
                if (frameEnd !== expFrameEnd) begin
                    syncErrors++;
                    $display("ERROR at %0t: frameEnd at scan (%0d,%0d) expected %b, seen %b",
                             $time, tx, ty, expFrameEnd, frameEnd);
                end
            end

            // Select starts high and flips after every PAD_PHASE_CYCLES clocks
            if (selCnt == `PAD_PHASE_CYCLES) begin
                selCnt = 0;
                expSel = !expSel;
            end
            selCnt++;
            if (padSelect !== expSel) begin
                buttonErrors++;
                $display("ERROR at %0t: padSelect expected %b, seen %b",
                         $time, expSel, padSelect);
            end

            if (sinceHFall >= 0) sinceHFall++;
            if (prevH && !hSync) begin
                if (sinceHFall > 0 && sinceHFall != lineCycles) begin
                    syncErrors++;
                    $display("ERROR at %0t: hSync period %0d cycles, expected %0d",
                             $time, sinceHFall, lineCycles);
                end
                sinceHFall = 0;
            end
            if (!hSync) begin
                hLow++;
            end else if (!prevH) begin
                if (hLow != 2 * `H_SYNC) begin
                    syncErrors++;
                    $display("ERROR at %0t: hSync low for %0d cycles, expected %0d",
                             $time, hLow, 2 * `H_SYNC);
                end
                hLow = 0;
            end
            if (!vSync) begin
                vLow++;
            end else if (!prevV) begin
                if (vLow != `V_SYNC * lineCycles) begin
                    syncErrors++;
                    $display("ERROR at %0t: vSync low for %0d cycles, expected %0d",
                             $time, vLow, `V_SYNC * lineCycles);
                end
                vLow = 0;
            end
            prevH = hSync;
            prevV = vSync;

            if (pressed !== lastPressed) begin
                lastPressed = pressed;
                sinceChange = 0;
            end else begin
                sinceChange++;
            end
            if (sinceChange == settleCycles && buttons !== pressed) begin
                buttonErrors++;
                $display("ERROR at %0t: buttons expected %02h, seen %02h",
                         $time, pressed, buttons);
            end

            if (frameEnd) begin
                stepSprite(buttons);
                frames++;
                if (frames == framesToRun) begin
                    if (!locked) begin
                        syncErrors++;
                        $display("No vSync pulse was seen, so pixels were never compared");
                    end
                    $display("Checker summary after %0d frames: sync errors %0d, %s %0d, %s %0d",
                             frames, syncErrors, "pixel errors", pixelErrors,
                             "button errors", buttonErrors);
                    done = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/gameBoxTb.sv ====
// Testbench for gameBox with clock, reset, a Sega pad model and a background
// loader. Random stimulus comes from an xorshift generator, the checker
// instance compares the outputs and this module ends the run
`timescale 1ns/1ps
`default_nettype none
`include "gameBox_macros.svh"

module gameBoxTb import videoPkg::*, inputPkg::*; ();

    localparam int resetCycles    = 8;
    localparam int frameCycles    = 2 * `H_TOTAL * `V_TOTAL;
    localparam int padHoldCycles  = 200000;
    // First frame is partial, five checked frames end before the sixth
    localparam int watchdogCycles = resetCycles + 6 * frameCycles;

    logic        clk;
    logic        rst;
    logic        pin1;
    logic        pin2;
    logic        pin3;
    logic        pin4;
    logic        pin6;
    logic        pin9;
    logic        padSelect;
    logic        bgWe;
    logic [14:0] bgAddr;
    logic        bgBit;
    logic        hSync;
    logic        vSync;
    rgbColor     rgb;
    padButtons   buttons;
    logic        frameEnd;

    // Buttons the pad model holds down
    padButtons   pressed;
    logic [31:0] rngState;

    // Copy of the bitmap, read by the checker
    logic bgCopy [0:`BG_DEPTH-1];

    logic checkDone;
    int   errorTotal;

    // Sega pad, active low pins multiplexed by select
    assign pin1 = ~pressed.up;
    assign pin2 = ~pressed.down;
    assign pin3 = padSelect ? ~pressed.left : 1'b0;
    assign pin4 = padSelect ? ~pressed.right : 1'b0;
    assign pin6 = padSelect ? ~pressed.b : ~pressed.a;
    assign pin9 = padSelect ? ~pressed.c : ~pressed.start;

    gameBox uut (
        .clk(clk), .rst(rst),
        .pin1(pin1), .pin2(pin2), .pin3(pin3), .pin4(pin4),
        .pin6(pin6), .pin9(pin9), .padSelect(padSelect),
        .bgWe(bgWe), .bgAddr(bgAddr), .bgBit(bgBit),
        .hSync(hSync), .vSync(vSync), .rgb(rgb),
        .buttons(buttons), .frameEnd(frameEnd)
    );

    gameBoxChecker outCheck (
        .clk(clk), .rst(rst),
        .hSync(hSync), .vSync(vSync), .rgb(rgb),
        .buttons(buttons), .frameEnd(frameEnd), .padSelect(padSelect),
        .pressed(pressed),
        .done(checkDone), .errorTotal(errorTotal)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] s;
        s = state;
        s ^= s << 13;
        s ^= s >> 17;
        s ^= s << 5;
        return s;
    endfunction

    // Writes every bitmap bit once, one per clk
    task automatic loadBackground();
        for (int i = 0; i < `BG_DEPTH; i++) begin
            rngState = xorshift32(rngState);
            bgCopy[i] = rngState[0];
            bgWe = 1'b1;
            bgAddr = 15'(i);
            bgBit = rngState[0];
            @(posedge clk);
            #2;
        end
        bgWe = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        bgWe = 1'b0;
        bgAddr = '0;
        bgBit = 1'b0;
        pressed = '0;
        rngState = 32'd2;
        repeat (resetCycles) @(posedge clk);
        #2;
        rst = 1'b0;
        loadBackground();
        forever begin
            repeat (padHoldCycles) @(posedge clk);
            #2;
            rngState = xorshift32(rngState);
            pressed = rngState[7:0];
        end
    end

    initial begin
        wait (checkDone);
        @(posedge clk);
        if (errorTotal == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("Timeout: the checker did not finish within %0d cycles", watchdogCycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/gameBox.sv ====
// Top level of the video subsystem on one 50 MHz clock
// Pad reader, VGA timing, sprite registers and the pixel mixer with its
// background RAM; bgWe/bgAddr/bgBit load the bitmap from outside
`timescale 1ns/1ps
`default_nettype none

module gameBox import videoPkg::*, inputPkg::*; (
    input  logic        clk,
    input  logic        rst,

    // Sega pad pins, active low
    input  logic        pin1,
    input  logic        pin2,
    input  logic        pin3,
    input  logic        pin4,
    input  logic        pin6,
    input  logic        pin9,
    output logic        padSelect,

    input  logic        bgWe,
    input  logic [14:0] bgAddr,
    input  logic        bgBit,

    output logic        hSync,
    output logic        vSync,
    output rgbColor     rgb,

    output padButtons   buttons,
    output logic        frameEnd
);

    pixelPos    pos;
    syncBits    sync;
    logic       pixEn;
    spriteState sprite;

    padReader pad (
        .clk(clk), .rst(rst),
        .pin1(pin1), .pin2(pin2), .pin3(pin3), .pin4(pin4),
        .pin6(pin6), .pin9(pin9),
        .padSelect(padSelect), .buttons(buttons)
    );

    videoTiming timing (
        .clk(clk), .rst(rst),
        .pos(pos), .sync(sync), .pixEn(pixEn), .frameEnd(frameEnd)
    );

    spriteRegs sprites (
        .clk(clk), .rst(rst),
        .frameEnd(frameEnd), .buttons(buttons), .sprite(sprite)
    );

    pixelMixer mixer (
        .clk(clk), .pixEn(pixEn),
        .pos(pos), .sync(sync), .sprite(sprite),
        .bgWe(bgWe), .bgBit(bgBit), .bgAddr(bgAddr),
        .hSync(hSync), .vSync(vSync), .rgb(rgb)
    );

endmodule

`default_nettype wire

// ==== verilog/gameBox_macros.svh ====
// Timing and geometry constants shared by the video blocks and the pad reader
// Include where the numbers are needed
`ifndef GAMEBOX_MACROS_SVH
`define GAMEBOX_MACROS_SVH

// 640x480 VGA line and frame timing in pixel ticks
`define H_VISIBLE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_TOTAL 800

`define V_VISIBLE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_TOTAL 525

// Sprite is square
`define SPRITE_SIZE 8

// Background bitmap is 160x120, one bit per 4x4 block
`define BG_SHIFT 2
`define BG_WIDTH 160
`define BG_DEPTH 19200

// clk cycles spent in each pad select phase
`define PAD_PHASE_CYCLES 512

`define X_START 316
`define Y_START 236

`endif

// ==== verilog/inputPkg.sv ====
// Types for the game controller side
// A set bit in padButtons means the button is held down
`default_nettype none

package inputPkg;

    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
        logic a;
        logic b;
        logic c;
        logic start;
    } padButtons;

endpackage

`default_nettype wire

// ==== verilog/padReader.sv ====
// Reads a 3-button Sega pad through its select line
// Select alternates every PAD_PHASE_CYCLES clocks; pins are sampled on the
// last cycle of each phase and the button set is refreshed after a low phase
`timescale 1ns/1ps
`default_nettype none
`include "gameBox_macros.svh"

module padReader import inputPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      pin1,
    input  logic      pin2,
    input  logic      pin3,
    input  logic      pin4,
    input  logic      pin6,
    input  logic      pin9,
    output logic      padSelect,
    output padButtons buttons
);

    localparam int phaseW = $clog2(`PAD_PHASE_CYCLES);
    localparam logic [phaseW-1:0] phaseLast = phaseW'(`PAD_PHASE_CYCLES - 1);

    logic [phaseW-1:0] phaseCnt;
    logic              selQ;

    // Held from the select-high phase: up, down, left, right
    logic [3:0] holdDir;
    logic       holdB;
    logic       holdC;

    padButtons btnQ;

    always_ff @(posedge clk) begin
        if (rst) begin
            phaseCnt <= '0;
            selQ     <= 1'b1;
            holdDir  <= '0;
            holdB    <= 1'b0;
            holdC    <= 1'b0;
            btnQ     <= '0;
        end else if (phaseCnt == phaseLast) begin
            phaseCnt <= '0;
            selQ     <= ~selQ;
            if (selQ) begin
                holdDir <= ~{pin1, pin2, pin3, pin4};
                holdB   <= ~pin6;
                holdC   <= ~pin9;
            end else begin
                // End of low phase, so the whole set is known now
                btnQ <= '{
                    up:    holdDir[3],
                    down:  holdDir[2],
                    left:  holdDir[1],
                    right: holdDir[0],
                    a:     ~pin6,
                    b:     holdB,
                    c:     holdC,
                    start: ~pin9
                };
            end
        end else begin
            phaseCnt <= phaseCnt + 1'b1;
        end
    end

    assign padSelect = selQ;
    assign buttons   = btnQ;

    // Select only moves together with the phase counter wrap
    selectOnWrap: assert property (
        @(posedge clk) disable iff (rst)
        $changed(padSelect) |-> phaseCnt == '0
    );

endmodule

`default_nettype wire

// ==== verilog/pixelMixer.sv ====
// Background bitmap RAM and the final pixel compositor
// The RAM read, sprite hit and syncs are lined up in one stage, then the
// colour and syncs are registered on the next pixel enable
`timescale 1ns/1ps
`default_nettype none
`include "gameBox_macros.svh"

module pixelMixer import videoPkg::*; (
    input  logic        clk,
    input  logic        pixEn,
    input  pixelPos     pos,
    input  syncBits     sync,
    input  spriteState  sprite,
    input  logic        bgWe,
    input  logic        bgBit,
    input  logic [14:0] bgAddr,
    output logic        hSync,
    output logic        vSync,
    output rgbColor     rgb
);

    localparam logic [14:0] bgWidth = 15'(`BG_WIDTH);

    logic memBits [0:`BG_DEPTH-1];

    logic [14:0] rdAddr;
    logic        spriteHit;

    // Stage aligned with the RAM read
    logic    bgQ;
    logic    hitQ;
    syncBits syncQ;

    rgbColor pixColor;

    // Output registers start idle, the same state the blanking gives
    logic    hSyncQ = 1'b1;
    logic    vSyncQ = 1'b1;
    rgbColor rgbQ   = '0;

    // Loaded by the external writer, no reset
    always_ff @(posedge clk) begin
        if (bgWe) begin
            memBits[bgAddr] <= bgBit;
        end
    end

    assign rdAddr = 15'(pos.y >> `BG_SHIFT) * bgWidth + 15'(pos.x >> `BG_SHIFT);

    // 11 bits so x + 8 cannot overflow
    assign spriteHit = sprite.shown
        && {1'b0, pos.x} >= {1'b0, sprite.x}
        && {1'b0, pos.x} <  {1'b0, sprite.x} + 11'(`SPRITE_SIZE)
        && {1'b0, pos.y} >= {1'b0, sprite.y}
        && {1'b0, pos.y} <  {1'b0, sprite.y} + 11'(`SPRITE_SIZE);

    always_ff @(posedge clk) begin
        bgQ   <= memBits[rdAddr];
        hitQ  <= spriteHit;
        syncQ <= sync;
    end

    always_comb begin
        if (!syncQ.visible) begin
            pixColor = '0;
        end else if (hitQ) begin
            case (sprite.colorIdx)
                2'd0:    pixColor = 12'hF00;
                2'd1:    pixColor = 12'h0F0;
                2'd2:    pixColor = 12'h00F;
                default: pixColor = 12'hFF0;
            endcase
        end else if (bgQ) begin
            pixColor = 12'hFFF;
        end else begin
            pixColor = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (pixEn) begin
            hSyncQ <= syncQ.hSync;
            vSyncQ <= syncQ.vSync;
            rgbQ   <= pixColor;
        end
    end

    assign hSync = hSyncQ;
    assign vSync = vSyncQ;
    assign rgb   = rgbQ;

    // Blank ticks leave a black pixel on the output one cycle later
    blankIsBlack: assert property (
        @(posedge clk)
        pixEn && !syncQ.visible |=> rgb == '0
    );

endmodule

`default_nettype wire

// ==== verilog/spriteRegs.sv ====
// Sprite state register, stepped once per frame at frameEnd
// Directions move one pixel each and are clamped to the screen, B recentres,
// A cycles the colour and a fresh Start press toggles visibility
`timescale 1ns/1ps
`default_nettype none
`include "gameBox_macros.svh"

module spriteRegs import videoPkg::*, inputPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       frameEnd,
    input  padButtons  buttons,
    output spriteState sprite
);

    localparam logic [9:0] xMax   = 10'(`H_VISIBLE - `SPRITE_SIZE);
    localparam logic [9:0] yMax   = 10'(`V_VISIBLE - `SPRITE_SIZE);
    localparam logic [9:0] xStart = 10'(`X_START);
    localparam logic [9:0] yStart = 10'(`Y_START);

    spriteState spr;
    logic       prevStart;

    // Net direction per axis, opposite buttons cancel
    logic goRight;
    logic goLeft;
    logic goDown;
    logic goUp;

    assign goRight = buttons.right && !buttons.left;
    assign goLeft  = buttons.left && !buttons.right;
    assign goDown  = buttons.down && !buttons.up;
    assign goUp    = buttons.up && !buttons.down;

    always_ff @(posedge clk) begin
        if (rst) begin
            spr       <= '{x: xStart, y: yStart, colorIdx: 2'd0, shown: 1'b1};
            prevStart <= 1'b0;
        end else if (frameEnd) begin
            if (buttons.b) begin
                spr.x <= xStart;
                spr.y <= yStart;
            end else begin
                // Steps stop at the edges instead of wrapping
                if (goRight && spr.x < xMax) begin
                    spr.x <= spr.x + 1'b1;
                end else if (goLeft && spr.x != '0) begin
                    spr.x <= spr.x - 1'b1;
                end
                if (goDown && spr.y < yMax) begin
                    spr.y <= spr.y + 1'b1;
                end else if (goUp && spr.y != '0) begin
                    spr.y <= spr.y - 1'b1;
                end
            end

            if (buttons.a) begin
                spr.colorIdx <= spr.colorIdx + 1'b1;
            end

            // Toggle on the press edge only, holding Start does nothing more
            if (buttons.start && !prevStart) begin
                spr.shown <= ~spr.shown;
            end
            prevStart <= buttons.start;
        end
    end

    assign sprite = spr;

    positionInBounds: assert property (
        @(posedge clk) disable iff (rst)
        sprite.x <= xMax && sprite.y <= yMax
    );

endmodule

`default_nettype wire

// ==== verilog/videoPkg.sv ====
// Types that describe the picture: scan position, colour, sync levels
// and the sprite registers. Imported by the video blocks and the top level
`default_nettype none

package videoPkg;

    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
    } pixelPos;

    // 4 bits per channel, as on the VGA connector
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgbColor;

    // Syncs are active low, visible is high inside the 640x480 area
    typedef struct packed {
        logic hSync;
        logic vSync;
        logic visible;
    } syncBits;

    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
        logic [1:0] colorIdx;
        logic       shown;
    } spriteState;

endpackage

`default_nettype wire

// ==== verilog/videoTiming.sv ====
// VGA 640x480 timing from a 50 MHz clock
// pixEn marks every second cycle; counters, syncs and visible follow it.
// frameEnd pulses on the tick that moves the scan to x 0, y 480
`timescale 1ns/1ps
`default_nettype none
`include "gameBox_macros.svh"

module videoTiming import videoPkg::*; (
    input  logic    clk,
    input  logic    rst,
    output pixelPos pos,
    output syncBits sync,
    output logic    pixEn,
    output logic    frameEnd
);

    localparam logic [9:0] hLast      = 10'(`H_TOTAL - 1);
    localparam logic [9:0] vLast      = 10'(`V_TOTAL - 1);
    localparam logic [9:0] hVisible   = 10'(`H_VISIBLE);
    localparam logic [9:0] vVisible   = 10'(`V_VISIBLE);
    localparam logic [9:0] hSyncStart = 10'(`H_VISIBLE + `H_FRONT);
    localparam logic [9:0] hSyncEnd   = 10'(`H_VISIBLE + `H_FRONT + `H_SYNC);
    localparam logic [9:0] vSyncStart = 10'(`V_VISIBLE + `V_FRONT);
    localparam logic [9:0] vSyncEnd   = 10'(`V_VISIBLE + `V_FRONT + `V_SYNC);

    logic       enToggle;
    logic [9:0] hCount;
    logic [9:0] vCount;

    always_ff @(posedge clk) begin
        if (rst) begin
            enToggle <= 1'b0;
            hCount   <= '0;
            vCount   <= '0;
        end else begin
            enToggle <= ~enToggle;
            if (enToggle) begin
                if (hCount == hLast) begin
                    hCount <= '0;
                    vCount <= (vCount == vLast) ? '0 : vCount + 1'b1;
                end else begin
                    hCount <= hCount + 1'b1;
                end
            end
        end
    end

    assign pixEn = enToggle;
    assign pos   = '{x: hCount, y: vCount};

    assign sync.hSync   = !(hCount >= hSyncStart && hCount < hSyncEnd);
    assign sync.vSync   = !(vCount >= vSyncStart && vCount < vSyncEnd);
    assign sync.visible = (hCount < hVisible) && (vCount < vVisible);

    // Last tick of the last visible line
    assign frameEnd = enToggle && (hCount == hLast) && (vCount == vVisible - 1'b1);

    countersInRange: assert property (
        @(posedge clk) disable iff (rst)
        hCount <= hLast && vCount <= vLast
    );

endmodule

`default_nettype wire
